//--- bench/eth_rx_top_tb.sv
`timescale 1ns/1ps

module eth_rx_top_tb;

    localparam int SW           = rx_mac_pkg::STAT_WIDTH;
    localparam int BW           = eth_frame_pkg::BYTE_WIDTH;
    localparam int NUM_FRAMES   = 60;
    localparam int IDLE_BYTES   = 12;       // dv low strobes after every frame
    localparam int BEAT_TIMEOUT = 200;      // Clocks allowed before each output byte

    // Frame kinds, the first eight frames walk through them in order
    localparam int K_GOOD      = 0;
    localparam int K_CRC       = 1;         // One FCS byte corrupted
    localparam int K_SHORT_PRE = 2;         // Fewer than seven preamble bytes
    localparam int K_BAD_SFD   = 3;
    localparam int K_RX_ER     = 4;         // rx_er on one payload byte
    localparam int K_GOOD2     = 5;
    localparam int K_DROP      = 6;         // fifo_ready low across the SFD
    localparam int K_READY_LOW = 7;         // fifo_ready low mid payload

    logic          clk = 1'b0;
    logic          reset_n;
    logic [BW-1:0] rx_data;
    logic          rx_dv;
    logic          rx_er;
    logic          rx_rdy;
    logic          fifo_ready;
    logic [BW-1:0] m_tdata;
    logic          m_tvalid;
    logic          m_tlast;
    logic          m_tuser;
    logic [SW-1:0] good_count;
    logic [SW-1:0] crc_err_count;
    logic [SW-1:0] abort_count;
    logic [SW-1:0] drop_count;

    // Stimulus stream for one frame, fifo_ready level set while each byte is presented
    rx_mac_pkg::rx_beat_t stim_q[$];
    logic                 ready_q[$];
    // Expected FIFO port traffic for one frame
    logic [BW-1:0]        exp_data_q[$];
    logic                 exp_last_q[$];
    logic                 exp_user_q[$];

    logic [SW-1:0] exp_good = '0;
    logic [SW-1:0] exp_crc_err = '0;
    logic [SW-1:0] exp_abort = '0;
    logic [SW-1:0] exp_drop = '0;
    int            exp_total = 0;           // Output bytes expected so far
    int            seen_beats = 0;          // Output bytes seen so far
    int            value_errors = 0;
    int            other_errors = 0;
    int            assert_failures = 0;     // From the bound checker
    logic          timed_out = 1'b0;
    logic [31:0]   lfsr = 32'h1d67;

    always #2 clk = ~clk;                   // 4 ns period

    eth_rx_top UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_data       (rx_data),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .rx_rdy        (rx_rdy),
        .fifo_ready    (fifo_ready),
        .m_tdata       (m_tdata),
        .m_tvalid      (m_tvalid),
        .m_tlast       (m_tlast),
        .m_tuser       (m_tuser),
        .good_count    (good_count),
        .crc_err_count (crc_err_count),
        .abort_count   (abort_count),
        .drop_count    (drop_count)
    );

    // Registered output, value of the cycle just ended
    always @(posedge clk) begin
        if (reset_n && m_tvalid) begin
            seen_beats++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference CRC
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);   // Galois, x^32+x^30+x^26+x^25+1
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);   // One step per bit taken
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Inverted reflected CRC-32 over the payload, sent low byte first
    function automatic logic [31:0] frame_fcs(input logic [BW-1:0] payload[$]);
        logic [31:0] crc;
        crc = eth_frame_pkg::CRC_INIT;
        foreach (payload[i]) begin
            crc = crc ^ {24'h0, payload[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ eth_frame_pkg::CRC_POLY_REFLECTED) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    function automatic void push_beat(input logic [BW-1:0] data, input logic dv, input logic er);
        stim_q.push_back('{data: data, dv: dv, er: er});
        ready_q.push_back(1'b1);
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic verify_byte(input string name, input logic [BW-1:0] got, input logic [BW-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s got 8'h%02h expected 8'h%02h", $time, name, got, exp);
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic count_equal(input string name, input logic [SW-1:0] got, input logic [SW-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model
    ////////////////////////////////////////////////////////////
    task automatic build_frame(input int kind);
        logic [BW-1:0] payload[$];
        logic [31:0]   fcs;
        logic [BW-1:0] sfd;
        int            pre_len;
        int            len;
        int            cut;                 // Payload byte that ends an aborted frame
        int            pos;
        int            sfd_at;
        stim_q.delete();
        ready_q.delete();
        exp_data_q.delete();
        exp_last_q.delete();
        exp_user_q.delete();
        pre_len = eth_frame_pkg::PREAMBLE_LEN;
        sfd     = eth_frame_pkg::SFD_BYTE;
        len     = random_bits(6) % 40 + 1;
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'(random_bits(8)));
        end
        fcs = frame_fcs(payload);
        cut = random_bits(6) % len;
        if (kind == K_SHORT_PRE) begin
            pre_len = random_bits(3) % 6 + 1;
        end
        if (kind == K_BAD_SFD) begin
            sfd = sfd ^ 8'(1 << (random_bits(3) % 7));  // Bit 7 would make it 0x55
        end
        if (kind == K_CRC) begin
            pos = random_bits(2);
            fcs[8*pos +: 8] = fcs[8*pos +: 8] ^ 8'(random_bits(8) | 1);
        end
        for (int i = 0; i < pre_len; i++) begin
            push_beat(eth_frame_pkg::PREAMBLE_BYTE, 1'b1, 1'b0);
        end
        sfd_at = stim_q.size();
        push_beat(sfd, 1'b1, 1'b0);
        foreach (payload[i]) begin
            push_beat(payload[i], 1'b1, (kind == K_RX_ER) && (i == cut));
        end
        for (int k = 0; k < eth_frame_pkg::FCS_BYTES; k++) begin
            push_beat(fcs[8*k +: 8], 1'b1, 1'b0);
        end
        for (int i = 0; i < IDLE_BYTES; i++) begin
            push_beat(8'h00, 1'b0, 1'b0);
        end
        // The level set with byte j is seen when byte j-5 is decided
        if (kind == K_DROP) begin
            for (int j = sfd_at + 3; j <= sfd_at + 7; j++) begin
                ready_q[j] = 1'b0;
            end
        end
        if (kind == K_READY_LOW) begin
            for (int j = sfd_at + 6 + cut; j <= sfd_at + 8 + cut; j++) begin
                ready_q[j] = 1'b0;
            end
        end
        case (kind)
            K_GOOD, K_GOOD2, K_CRC: begin
                foreach (payload[i]) begin
                    exp_data_q.push_back(payload[i]);
                    exp_last_q.push_back(i == len - 1);
                    exp_user_q.push_back((kind == K_CRC) && (i == len - 1));
                end
                if (kind == K_CRC) begin
                    exp_crc_err++;
                end else begin
                    exp_good++;
                end
            end
            K_RX_ER, K_READY_LOW: begin
                for (int i = 0; i <= cut; i++) begin
                    exp_data_q.push_back(payload[i]);
                    exp_last_q.push_back(1'b0);
                    exp_user_q.push_back(i == cut);   // Flag rides on the cut byte
                end
                exp_abort++;
            end
            K_DROP: exp_drop++;
            default: ;                                // No start of frame, no output
        endcase
        exp_total += exp_data_q.size();
    endtask

    ////////////////////////////////////////////////////////////
    // Driver and output collector
    ////////////////////////////////////////////////////////////
    task automatic drive_frame();
        int gap;
        foreach (stim_q[j]) begin
            @(negedge clk);
            rx_data    = stim_q[j].data;    // Next byte shows during the gap
            rx_dv      = stim_q[j].dv;
            rx_er      = stim_q[j].er;
            fifo_ready = ready_q[j];
            rx_rdy     = 1'b0;
            gap        = random_bits(2);
            repeat (gap + 1) @(negedge clk);    // Strobes at least two clocks apart
            rx_rdy = 1'b1;
        end
        @(negedge clk);
        rx_rdy = 1'b0;
    endtask

    task automatic collect_output();
        int waited;
        foreach (exp_data_q[i]) begin
            waited = 0;
            @(negedge clk);
            while (!m_tvalid && waited < BEAT_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!m_tvalid) begin
                other_errors++;
                timed_out = 1'b1;
                $display("Timeout at t=%0t: output byte %0d of the frame never came", $time, i);
                return;
            end
            verify_byte("m_tdata", m_tdata, exp_data_q[i]);
            flag_compare("m_tlast", m_tlast, exp_last_q[i]);
            flag_compare("m_tuser", m_tuser, exp_user_q[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        reset_n    = 1'b0;
        rx_data    = '0;
        rx_dv      = 1'b0;
        rx_er      = 1'b0;
        rx_rdy     = 1'b0;
        fifo_ready = 1'b1;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (4) @(negedge clk);
        for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
            build_frame((f < 8) ? f : random_bits(3));
            fork
                drive_frame();
                collect_output();
            join
            if (!timed_out) begin
                if (seen_beats != exp_total) begin
                    other_errors++;
                    $display("Frame %0d: %0d output bytes seen, %0d expected so far",
                             f, seen_beats, exp_total);
                end
                count_equal("good_count", good_count, exp_good);
                count_equal("crc_err_count", crc_err_count, exp_crc_err);
                count_equal("abort_count", abort_count, exp_abort);
                count_equal("drop_count", drop_count, exp_drop);
            end
        end
        assert_failures = UUT.u_mac.u_mac_checker.fail_count;
        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, assert_failures);
        if (value_errors == 0 && other_errors == 0 && assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/rx_mac_checker.sv
`timescale 1ns/1ps

module rx_mac_checker (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       m_tvalid,
    input  logic                       m_tlast,
    input  logic                       m_tuser,
    input  logic                       crc_init,
    input  rx_mac_pkg::frame_outcome_t outcome
);

    int fail_count = 0;                 // Assertion failures so far

    ////////////////////////////////////////////////////////////
    // FIFO port shape
    ////////////////////////////////////////////////////////////
    flags_need_valid: assert property (@(posedge clk) disable iff (!reset_n)
        (m_tlast || m_tuser) |-> m_tvalid)
        else begin
            fail_count++;
            $error("m_tlast or m_tuser raised without m_tvalid");
        end

    // One cycle per byte, strobes never come faster
    valid_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        m_tvalid |=> !m_tvalid)
        else begin
            fail_count++;
            $error("m_tvalid held for two cycles");
        end

    // Sync reset clears the registered outputs on the next clock
    quiet_after_reset: assert property (@(posedge clk)
        !reset_n |=> (!m_tvalid && !m_tlast && !m_tuser &&
                      outcome == rx_mac_pkg::OUT_NONE))
        else begin
            fail_count++;
            $error("FIFO port or outcome active after reset");
        end

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    outcome_not_at_start: assert property (@(posedge clk) disable iff (!reset_n)
        !(outcome != rx_mac_pkg::OUT_NONE && crc_init))
        else begin
            fail_count++;
            $error("outcome pulse in the same cycle as crc_init");
        end

endmodule

bind rx_mac rx_mac_checker u_mac_checker (
    .clk      (clk),
    .reset_n  (reset_n),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast),
    .m_tuser  (m_tuser),
    .crc_init (crc_init),
    .outcome  (outcome)
);

//--- eth_rx_top.f
source/eth_frame_pkg.sv
source/rx_mac_pkg.sv
source/rx_tap_if.sv
source/rx_delay_line.sv
source/preamble_detector.sv
source/crc32_engine.sv
source/rx_frame_stats.sv
source/rx_mac.sv
source/eth_rx_top.sv
bench/rx_mac_checker.sv
bench/eth_rx_top_tb.sv

//--- source/crc32_engine.sv
`timescale 1ns/1ps

module crc32_engine (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     crc_init,              // Load seed at start of frame
    input  logic     crc_en,                // Absorb oldest byte this clock
    rx_tap_if.sink   taps,
    output logic     crc_match              // FCS taps equal CRC through current byte
);

    localparam int CW = eth_frame_pkg::CRC_WIDTH;
    localparam int BW = eth_frame_pkg::BYTE_WIDTH;

    logic [CW-1:0] crc_state;
    logic [CW-1:0] crc_next;

    ////////////////////////////////////////////////////////////
    // Reflected update, one bit step per data bit, LSB first
    ////////////////////////////////////////////////////////////
    always_comb begin
        crc_next = crc_state ^ {{(CW-BW){1'b0}}, taps.oldest.data};
        for (int b = 0; b < BW; b++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ eth_frame_pkg::CRC_POLY_REFLECTED;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || crc_init) begin
            crc_state <= eth_frame_pkg::CRC_INIT;
        end else if (crc_en) begin
            crc_state <= crc_next;
        end
    end

    // Transmitted FCS is the inverted remainder
    assign crc_match = (~crc_next == taps.fcs_word);

endmodule

//--- source/eth_frame_pkg.sv
package eth_frame_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////
    localparam int BYTE_WIDTH = 8;          // One octet per strobe
    localparam int CRC_WIDTH  = 32;         // CRC-32 and FCS field

    ////////////////////////////////////////////////////////////
    // Frame start
    ////////////////////////////////////////////////////////////
    localparam logic [BYTE_WIDTH-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [BYTE_WIDTH-1:0] SFD_BYTE      = 8'hD5;
    localparam int                    PREAMBLE_LEN  = 7;    // Preamble bytes before SFD

    ////////////////////////////////////////////////////////////
    // Frame check sequence
    ////////////////////////////////////////////////////////////
    localparam logic [CRC_WIDTH-1:0] CRC_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [CRC_WIDTH-1:0] CRC_INIT           = 32'hFFFFFFFF;
    localparam int                   FCS_BYTES          = 4;

    // Oldest stage plus the four bytes that could be the FCS
    localparam int DELAY_STAGES = FCS_BYTES + 1;

endpackage

//--- source/eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top (
    input  logic                                 clk,
    input  logic                                 reset_n,
    // Byte stream from the PHY interface
    input  logic [eth_frame_pkg::BYTE_WIDTH-1:0] rx_data,
    input  logic                                 rx_dv,
    input  logic                                 rx_er,
    input  logic                                 rx_rdy,
    // FIFO write port
    input  logic                                 fifo_ready,
    output logic [eth_frame_pkg::BYTE_WIDTH-1:0] m_tdata,
    output logic                                 m_tvalid,
    output logic                                 m_tlast,
    output logic                                 m_tuser,
    // Statistics
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]    good_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]    crc_err_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]    abort_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]    drop_count
);

    rx_tap_if                   taps ();
    logic                       sof_seen;
    logic                       crc_init, crc_en, crc_match;
    rx_mac_pkg::frame_outcome_t outcome;

    ////////////////////////////////////////////////////////////
    // Front end
    ////////////////////////////////////////////////////////////
    rx_delay_line u_delay (
        .clk     (clk),
        .reset_n (reset_n),
        .rx_data (rx_data),
        .rx_dv   (rx_dv),
        .rx_er   (rx_er),
        .rx_rdy  (rx_rdy),
        .taps    (taps.source)
    );

    preamble_detector u_pre (
        .clk      (clk),
        .reset_n  (reset_n),
        .taps     (taps.sink),
        .sof_seen (sof_seen)
    );

    crc32_engine u_crc (
        .clk       (clk),
        .reset_n   (reset_n),
        .crc_init  (crc_init),
        .crc_en    (crc_en),
        .taps      (taps.sink),
        .crc_match (crc_match)
    );

    ////////////////////////////////////////////////////////////
    // Control and counters
    ////////////////////////////////////////////////////////////
    rx_mac u_mac (
        .clk        (clk),
        .reset_n    (reset_n),
        .taps       (taps.sink),
        .sof_seen   (sof_seen),
        .crc_match  (crc_match),
        .fifo_ready (fifo_ready),
        .crc_init   (crc_init),
        .crc_en     (crc_en),
        .outcome    (outcome),
        .m_tdata    (m_tdata),
        .m_tvalid   (m_tvalid),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser)
    );

    rx_frame_stats u_stats (
        .clk           (clk),
        .reset_n       (reset_n),
        .outcome       (outcome),
        .good_count    (good_count),
        .crc_err_count (crc_err_count),
        .abort_count   (abort_count),
        .drop_count    (drop_count)
    );

endmodule

//--- source/preamble_detector.sv
`timescale 1ns/1ps

module preamble_detector (
    input  logic     clk,
    input  logic     reset_n,
    rx_tap_if.sink   taps,
    output logic     sof_seen               // SFD at oldest tap after a full preamble
);

    localparam logic [2:0] FULL = 3'(eth_frame_pkg::PREAMBLE_LEN);

    logic [2:0] run_cnt;                    // Consecutive preamble beats, saturating
    logic       is_pre;
    logic       is_sfd;

    assign is_pre = taps.oldest.dv && (taps.oldest.data == eth_frame_pkg::PREAMBLE_BYTE);
    assign is_sfd = taps.oldest.dv && (taps.oldest.data == eth_frame_pkg::SFD_BYTE);

    ////////////////////////////////////////////////////////////
    // Run counter, advances once per shifted beat
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            run_cnt <= '0;
        end else if (taps.shift) begin
            if (!is_pre) begin
                run_cnt <= '0;                  // Any other beat breaks the run
            end else if (run_cnt != FULL) begin
                run_cnt <= run_cnt + 3'd1;
            end
        end
    end

    // Counter still holds the run before this beat
    assign sof_seen = (run_cnt == FULL) && is_sfd;

endmodule

//--- source/rx_delay_line.sv
`timescale 1ns/1ps

module rx_delay_line (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [eth_frame_pkg::BYTE_WIDTH-1:0] rx_data,
    input  logic                                rx_dv,
    input  logic                                rx_er,
    input  logic                                rx_rdy,    // One strobe per received byte
    rx_tap_if.source                            taps
);

    localparam int STAGES = eth_frame_pkg::DELAY_STAGES;
    localparam int FCS_N  = eth_frame_pkg::FCS_BYTES;
    localparam int BW     = eth_frame_pkg::BYTE_WIDTH;

    rx_mac_pkg::rx_beat_t stage [STAGES];      // stage[0] youngest, stage[STAGES-1] oldest
    logic                 shift_q;

    ////////////////////////////////////////////////////////////
    // Strobe-gated shift register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= '0;
            end
            shift_q <= 1'b0;
        end else begin
            shift_q <= rx_rdy;                 // Marks the cycle after a move
            if (rx_rdy) begin
                stage[0] <= '{data: rx_data, dv: rx_dv, er: rx_er};
                for (int i = 1; i < STAGES; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end
    end

    // Received FCS arrives LSB byte first, so the earliest FCS byte lands low
    always_comb begin
        for (int k = 0; k < FCS_N; k++) begin
            taps.fcs_word[BW*k +: BW] = stage[FCS_N-1-k].data;
        end
    end

    assign taps.shift  = shift_q;
    assign taps.oldest = stage[STAGES-1];
    assign taps.in_dv  = rx_dv;                // Not delayed

endmodule

//--- source/rx_frame_stats.sv
`timescale 1ns/1ps

module rx_frame_stats (
    input  logic                                clk,
    input  logic                                reset_n,
    input  rx_mac_pkg::frame_outcome_t          outcome,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]   good_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]   crc_err_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]   abort_count,
    output logic [rx_mac_pkg::STAT_WIDTH-1:0]   drop_count
);

    localparam int SW = rx_mac_pkg::STAT_WIDTH;

    logic [SW-1:0] cnt [4];                     // Indexed by outcome code minus one
    logic [1:0]    sel;

    // OUT_GOOD maps to 0 ... OUT_DROP maps to 3
    assign sel = 2'(3'(outcome) - 3'd1);

    ////////////////////////////////////////////////////////////
    // Saturating counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= '0;
            end
        end else if (outcome != rx_mac_pkg::OUT_NONE && cnt[sel] != '1) begin
            cnt[sel] <= cnt[sel] + 1'b1;        // Hold at all ones
        end
    end

    assign good_count    = cnt[0];
    assign crc_err_count = cnt[1];
    assign abort_count   = cnt[2];
    assign drop_count    = cnt[3];

endmodule

//--- source/rx_mac.sv
`timescale 1ns/1ps

module rx_mac (
    input  logic                                 clk,
    input  logic                                 reset_n,
    rx_tap_if.sink                               taps,
    input  logic                                 sof_seen,
    input  logic                                 crc_match,
    input  logic                                 fifo_ready,   // Sampled level
    output logic                                 crc_init,
    output logic                                 crc_en,
    output rx_mac_pkg::frame_outcome_t           outcome,      // One pulse per frame
    output logic [eth_frame_pkg::BYTE_WIDTH-1:0] m_tdata,
    output logic                                 m_tvalid,
    output logic                                 m_tlast,
    output logic                                 m_tuser       // Error on this byte
);

    rx_mac_pkg::rx_state_t      state, state_next;
    rx_mac_pkg::frame_outcome_t outcome_next;
    logic                       tvalid_next, tlast_next, tuser_next;
    logic                       bad_byte;           // Abort condition at oldest tap

    assign bad_byte = taps.oldest.er || !taps.oldest.dv || !fifo_ready;

    ////////////////////////////////////////////////////////////
    // Next state, evaluated only on shift cycles
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_next   = state;
        outcome_next = rx_mac_pkg::OUT_NONE;
        tvalid_next  = 1'b0;
        tlast_next   = 1'b0;
        tuser_next   = 1'b0;
        if (taps.shift) begin
            case (state)
                rx_mac_pkg::IDLE: begin
                    if (sof_seen && fifo_ready) begin
                        state_next = rx_mac_pkg::PAYLOAD;
                    end else if (sof_seen) begin
                        state_next   = rx_mac_pkg::DISCARD;     // No room, drop it whole
                        outcome_next = rx_mac_pkg::OUT_DROP;
                    end
                end
                rx_mac_pkg::PAYLOAD: begin
                    tvalid_next = 1'b1;                     // Every payload beat goes out
                    if (bad_byte) begin
                        tuser_next   = 1'b1;                // Flag and stop here
                        state_next   = rx_mac_pkg::DISCARD;
                        outcome_next = rx_mac_pkg::OUT_ABORT;
                    end else if (!taps.in_dv) begin
                        // Stages 0..3 now hold the FCS
                        tlast_next   = 1'b1;
                        tuser_next   = !crc_match;
                        state_next   = rx_mac_pkg::IDLE;
                        outcome_next = crc_match ? rx_mac_pkg::OUT_GOOD
                                                 : rx_mac_pkg::OUT_CRC_ERR;
                    end
                end
                rx_mac_pkg::DISCARD: begin
                    if (!taps.oldest.dv) begin
                        state_next = rx_mac_pkg::IDLE;      // Frame has drained
                    end
                end
                default: state_next = rx_mac_pkg::IDLE;
            endcase
        end
    end

    // CRC seeded on the SFD beat, fed on every payload beat
    assign crc_init = taps.shift && (state == rx_mac_pkg::IDLE) && sof_seen && fifo_ready;
    assign crc_en   = taps.shift && (state == rx_mac_pkg::PAYLOAD);

    ////////////////////////////////////////////////////////////
    // Registered FIFO port and outcome
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= rx_mac_pkg::IDLE;
            outcome  <= rx_mac_pkg::OUT_NONE;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
            m_tuser  <= 1'b0;
        end else begin
            state    <= state_next;
            outcome  <= outcome_next;
            m_tvalid <= tvalid_next;
            m_tlast  <= tlast_next;
            m_tuser  <= tuser_next;
        end
    end

    always_ff @(posedge clk) begin
        if (tvalid_next) begin
            m_tdata <= taps.oldest.data;           // Byte under decision
        end
    end

endmodule

//--- source/rx_mac_pkg.sv
package rx_mac_pkg;

    // One received byte with its PHY flags, 10 bits
    typedef struct packed {
        logic [eth_frame_pkg::BYTE_WIDTH-1:0] data;
        logic                                 dv;     // Data valid level
        logic                                 er;     // Receive error level
    } rx_beat_t;

    // Control FSM
    typedef enum logic [1:0] {
        IDLE,                                   // Waiting for preamble and SFD
        PAYLOAD,                                // Streaming bytes to the FIFO
        DISCARD                                 // Dropping rest of a bad frame
    } rx_state_t;

    // Width of every statistics counter
    localparam int STAT_WIDTH = 16;

    // Per-frame result, pulsed once at the decision point
    typedef enum logic [2:0] {
        OUT_NONE,
        OUT_GOOD,                               // FCS matched
        OUT_CRC_ERR,                            // FCS mismatch
        OUT_ABORT,                              // rx_er or FIFO not ready mid-frame
        OUT_DROP                                // FIFO not ready at start of frame
    } frame_outcome_t;

endpackage

//--- source/rx_tap_if.sv
`timescale 1ns/1ps

interface rx_tap_if;

    logic                                      shift;    // Stages moved last clock
    rx_mac_pkg::rx_beat_t                      oldest;   // Stage 4, byte under decision
    logic [eth_frame_pkg::CRC_WIDTH-1:0]       fcs_word; // Stages 0..3, stage 3 in low byte

    // Live rx_dv level; falls once the final byte of a frame has been strobed
    logic                                      in_dv;

    // Delay line side
    modport source (
        output shift,
        output oldest,
        output fcs_word,
        output in_dv
    );

    // Detector, CRC engine and control
    modport sink (
        input shift,
        input oldest,
        input fcs_word,
        input in_dv
    );

endinterface
